// File: design/evc_pkg.sv
package evc_pkg;

  localparam int axi_data_width = 32;   // Bus data and register word size
  localparam int axi_addr_width = 32;
  localparam int addr_lsb       = 2;    // Byte offset bits, ignored in addresses
  localparam int num_channels   = 4;
  localparam int cfg_words      = 2;
  localparam int sts_words      = 5;

  // Config word 0 holds enable and clear, word 1 the shared limit
  typedef struct packed
  {
    logic [axi_data_width-1:0]                limit;     // Word 1
    logic [axi_data_width-2*num_channels-1:0] reserved;
    logic [num_channels-1:0]                  clear;     // Word 0 bits 7..4
    logic [num_channels-1:0]                  enable;    // Word 0 bits 3..0
  } cfg_t;

  // Status words 0..3 are the counts, word 4 the limit flags
  typedef struct packed
  {
    logic [axi_data_width-num_channels-1:0]      reserved;
    logic [num_channels-1:0]                     flags;     // Word 4
    logic [num_channels-1:0][axi_data_width-1:0] count;     // count[i] in word i
  } sts_t;

  typedef enum logic
  {
    wr_idle,
    wr_resp
  } wr_state_t;

endpackage

// File: design/axi_cfg_register.sv
`timescale 1ns/1ps

module axi_cfg_register
(
  input  logic                                                  aclk,
  input  logic                                                  aresetn,

  input  logic [evc_pkg::axi_addr_width-1:0]                    s_axi_awaddr,
  input  logic                                                  s_axi_awvalid,
  output logic                                                  s_axi_awready,
  input  logic [evc_pkg::axi_data_width-1:0]                    s_axi_wdata,
  input  logic                                                  s_axi_wvalid,
  output logic                                                  s_axi_wready,
  output logic [1:0]                                            s_axi_bresp,
  output logic                                                  s_axi_bvalid,
  input  logic                                                  s_axi_bready,
  input  logic [evc_pkg::axi_addr_width-1:0]                    s_axi_araddr,
  input  logic                                                  s_axi_arvalid,
  output logic                                                  s_axi_arready,
  output logic [evc_pkg::axi_data_width-1:0]                    s_axi_rdata,
  output logic [1:0]                                            s_axi_rresp,
  output logic                                                  s_axi_rvalid,
  input  logic                                                  s_axi_rready,

  output logic [evc_pkg::cfg_words*evc_pkg::axi_data_width-1:0] cfg_data
);

  import evc_pkg::*;

  logic [axi_data_width-1:0]          int_cfg_regs [cfg_words];
  wr_state_t                          wr_state_reg, wr_state_next;
  logic                               int_wready_reg, int_wready_next;
  logic                               int_bvalid_reg, int_bvalid_next;
  logic                               int_arready_reg, int_arready_next;
  logic                               int_rvalid_reg, int_rvalid_next;
  logic [axi_data_width-1:0]          int_rdata_reg, int_rdata_next;
  logic [axi_data_width-1:0]          rd_word;
  logic [axi_addr_width-addr_lsb-1:0] wr_index;
  logic [axi_addr_width-addr_lsb-1:0] rd_index;
  logic                               wr_accept;
  logic                               rd_accept;

  assign wr_index  = s_axi_awaddr[axi_addr_width-1:addr_lsb];
  assign rd_index  = s_axi_araddr[axi_addr_width-1:addr_lsb];
  assign wr_accept = (wr_state_reg == wr_idle) & s_axi_awvalid & s_axi_wvalid;
  // A new read waits until the previous data has been taken
  assign rd_accept = s_axi_arvalid & ~int_arready_reg & ~int_rvalid_reg;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      for (int i = 0; i < cfg_words; i++)
      begin
        int_cfg_regs[i] <= '0;                    // All channels disabled
      end
    end
    else if (wr_accept)
    begin
      for (int i = 0; i < cfg_words; i++)
      begin
        if (wr_index == i)
        begin
          int_cfg_regs[i] <= s_axi_wdata;         // Out-of-range writes are dropped
        end
      end
    end
  end

  always_comb
  begin
    wr_state_next   = wr_state_reg;
    int_wready_next = 1'b0;                       // One-cycle pulse
    int_bvalid_next = int_bvalid_reg;
    case (wr_state_reg)
      wr_idle:
      begin
        if (wr_accept)
        begin
          int_wready_next = 1'b1;
          int_bvalid_next = 1'b1;
          wr_state_next   = wr_resp;
        end
      end
      wr_resp:
      begin
        if (s_axi_bready)
        begin
          int_bvalid_next = 1'b0;
          wr_state_next   = wr_idle;
        end
      end
      default: wr_state_next = wr_idle;
    endcase
  end

  always_comb
  begin
    rd_word = '0;                                 // Unmapped words read zero
    for (int i = 0; i < cfg_words; i++)
    begin
      if (rd_index == i)
      begin
        rd_word = int_cfg_regs[i];
      end
    end
  end

  always_comb
  begin
    int_arready_next = 1'b0;
    int_rvalid_next  = int_rvalid_reg;
    int_rdata_next   = int_rdata_reg;
    if (rd_accept)
    begin
      int_arready_next = 1'b1;
      int_rvalid_next  = 1'b1;
      int_rdata_next   = rd_word;
    end
    if (s_axi_rready & int_rvalid_reg)
    begin
      int_rvalid_next = 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_state_reg    <= wr_idle;
      int_wready_reg  <= 1'b0;
      int_bvalid_reg  <= 1'b0;
      int_arready_reg <= 1'b0;
      int_rvalid_reg  <= 1'b0;
    end
    else
    begin
      wr_state_reg    <= wr_state_next;
      int_wready_reg  <= int_wready_next;
      int_bvalid_reg  <= int_bvalid_next;
      int_arready_reg <= int_arready_next;
      int_rvalid_reg  <= int_rvalid_next;
    end
  end

  always_ff @(posedge aclk)
  begin
    int_rdata_reg <= int_rdata_next;
  end

  genvar j;
  generate
    for (j = 0; j < cfg_words; j++)
    begin : g_flat
      assign cfg_data[j*axi_data_width +: axi_data_width] = int_cfg_regs[j];
    end
  endgenerate

  assign s_axi_awready = int_wready_reg;          // Address and data taken together
  assign s_axi_wready  = int_wready_reg;
  assign s_axi_bresp   = 2'd0;
  assign s_axi_bvalid  = int_bvalid_reg;
  assign s_axi_arready = int_arready_reg;
  assign s_axi_rdata   = int_rdata_reg;
  assign s_axi_rresp   = 2'd0;
  assign s_axi_rvalid  = int_rvalid_reg;

  assert property (@(posedge aclk) disable iff (!aresetn)
    (wr_state_reg == wr_idle) |-> !s_axi_bvalid);

  assert property (@(posedge aclk) disable iff (!aresetn)
    s_axi_arready |=> !s_axi_arready);

endmodule

// File: design/axi_sts_register.sv
`timescale 1ns/1ps

module axi_sts_register
(
  input  logic                                                  aclk,
  input  logic                                                  aresetn,

  input  logic [evc_pkg::sts_words*evc_pkg::axi_data_width-1:0] sts_data,

  input  logic [evc_pkg::axi_addr_width-1:0]                    s_axi_araddr,
  input  logic                                                  s_axi_arvalid,
  output logic                                                  s_axi_arready,
  output logic [evc_pkg::axi_data_width-1:0]                    s_axi_rdata,
  output logic [1:0]                                            s_axi_rresp,
  output logic                                                  s_axi_rvalid,
  input  logic                                                  s_axi_rready
);

  import evc_pkg::*;

  logic                               int_arready_reg, int_arready_next;
  logic                               int_rvalid_reg, int_rvalid_next;
  logic [axi_data_width-1:0]          int_rdata_reg, int_rdata_next;
  logic [axi_data_width-1:0]          rd_word;
  logic [axi_addr_width-addr_lsb-1:0] rd_index;
  logic                               rd_accept;

  assign rd_index  = s_axi_araddr[axi_addr_width-1:addr_lsb];
  assign rd_accept = s_axi_arvalid & ~int_arready_reg & ~int_rvalid_reg;

  always_comb
  begin
    rd_word = '0;                                 // Index past the last word
    for (int i = 0; i < sts_words; i++)
    begin
      if (rd_index == i)
      begin
        rd_word = sts_data[i*axi_data_width +: axi_data_width];
      end
    end
  end

  always_comb
  begin
    int_arready_next = 1'b0;
    int_rvalid_next  = int_rvalid_reg;
    int_rdata_next   = int_rdata_reg;
    if (rd_accept)
    begin
      int_arready_next = 1'b1;
      int_rvalid_next  = 1'b1;
      int_rdata_next   = rd_word;                 // Snapshot of the live status
    end
    if (s_axi_rready & int_rvalid_reg)
    begin
      int_rvalid_next = 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      int_arready_reg <= 1'b0;
      int_rvalid_reg  <= 1'b0;
    end
    else
    begin
      int_arready_reg <= int_arready_next;
      int_rvalid_reg  <= int_rvalid_next;
    end
  end

  always_ff @(posedge aclk)
  begin
    int_rdata_reg <= int_rdata_next;
  end

  assign s_axi_arready = int_arready_reg;
  assign s_axi_rdata   = int_rdata_reg;
  assign s_axi_rresp   = 2'd0;
  assign s_axi_rvalid  = int_rvalid_reg;

  // Counts keep moving, the returned word must not
  assert property (@(posedge aclk) disable iff (!aresetn)
    (s_axi_rvalid && !s_axi_rready) |=> $stable(s_axi_rdata));

endmodule

// File: design/event_counter_bank.sv
`timescale 1ns/1ps

module event_counter_bank
(
  input  logic                             aclk,
  input  logic                             aresetn,
  input  logic [evc_pkg::num_channels-1:0] event_in,
  input  evc_pkg::cfg_t                    cfg,
  output evc_pkg::sts_t                    sts
);

  import evc_pkg::*;

  logic [num_channels-1:0]                     event_reg;
  logic [num_channels-1:0]                     event_rise;
  logic [num_channels-1:0]                     at_limit;
  logic [num_channels-1:0][axi_data_width-1:0] count_reg;
  logic [num_channels-1:0]                     flags_reg;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      event_reg <= '0;
    end
    else
    begin
      event_reg <= event_in;                      // Delayed copy for edge detect
    end
  end

  assign event_rise = event_in & ~event_reg;

  always_comb
  begin
    for (int i = 0; i < num_channels; i++)
    begin
      // A zero limit never raises a flag
      at_limit[i] = (cfg.limit != '0) && (count_reg[i] >= cfg.limit);
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      count_reg <= '0;
      flags_reg <= '0;
    end
    else
    begin
      for (int i = 0; i < num_channels; i++)
      begin
        if (cfg.clear[i])
        begin
          count_reg[i] <= '0;
          flags_reg[i] <= 1'b0;
        end
        else
        begin
          if (cfg.enable[i] && event_rise[i])
          begin
            count_reg[i] <= count_reg[i] + 1'b1;  // Wraps at 32 bits
          end
          if (at_limit[i])
          begin
            flags_reg[i] <= 1'b1;                 // Sticky until clear
          end
        end
      end
    end
  end

  assign sts.reserved = '0;
  assign sts.flags    = flags_reg;
  assign sts.count    = count_reg;

  // Clear bits come from the config block one cycle behind the write
  assert property (@(posedge aclk) disable iff (!aresetn)
    (cfg.clear != '0) |=> ((sts.flags & $past(cfg.clear)) == '0));

endmodule

// File: design/evc_top.sv
`timescale 1ns/1ps

module evc_top
(
  input  logic                                 aclk,
  input  logic                                 aresetn,
  input  logic [evc_pkg::num_channels-1:0]     event_in,

  input  logic [evc_pkg::axi_addr_width-1:0]   s_axi_cfg_awaddr,
  input  logic                                 s_axi_cfg_awvalid,
  output logic                                 s_axi_cfg_awready,
  input  logic [evc_pkg::axi_data_width-1:0]   s_axi_cfg_wdata,
  input  logic                                 s_axi_cfg_wvalid,
  output logic                                 s_axi_cfg_wready,
  output logic [1:0]                           s_axi_cfg_bresp,
  output logic                                 s_axi_cfg_bvalid,
  input  logic                                 s_axi_cfg_bready,
  input  logic [evc_pkg::axi_addr_width-1:0]   s_axi_cfg_araddr,
  input  logic                                 s_axi_cfg_arvalid,
  output logic                                 s_axi_cfg_arready,
  output logic [evc_pkg::axi_data_width-1:0]   s_axi_cfg_rdata,
  output logic [1:0]                           s_axi_cfg_rresp,
  output logic                                 s_axi_cfg_rvalid,
  input  logic                                 s_axi_cfg_rready,

  input  logic [evc_pkg::axi_addr_width-1:0]   s_axi_sts_araddr,
  input  logic                                 s_axi_sts_arvalid,
  output logic                                 s_axi_sts_arready,
  output logic [evc_pkg::axi_data_width-1:0]   s_axi_sts_rdata,
  output logic [1:0]                           s_axi_sts_rresp,
  output logic                                 s_axi_sts_rvalid,
  input  logic                                 s_axi_sts_rready
);

  import evc_pkg::*;

  logic [cfg_words*axi_data_width-1:0] cfg_data;   // Flat config words
  sts_t                                sts;

  axi_cfg_register u_cfg
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axi_awaddr  (s_axi_cfg_awaddr),
    .s_axi_awvalid (s_axi_cfg_awvalid),
    .s_axi_awready (s_axi_cfg_awready),
    .s_axi_wdata   (s_axi_cfg_wdata),
    .s_axi_wvalid  (s_axi_cfg_wvalid),
    .s_axi_wready  (s_axi_cfg_wready),
    .s_axi_bresp   (s_axi_cfg_bresp),
    .s_axi_bvalid  (s_axi_cfg_bvalid),
    .s_axi_bready  (s_axi_cfg_bready),
    .s_axi_araddr  (s_axi_cfg_araddr),
    .s_axi_arvalid (s_axi_cfg_arvalid),
    .s_axi_arready (s_axi_cfg_arready),
    .s_axi_rdata   (s_axi_cfg_rdata),
    .s_axi_rresp   (s_axi_cfg_rresp),
    .s_axi_rvalid  (s_axi_cfg_rvalid),
    .s_axi_rready  (s_axi_cfg_rready),
    .cfg_data      (cfg_data)
  );

  event_counter_bank u_bank
  (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .event_in (event_in),
    .cfg      (cfg_t'(cfg_data)),
    .sts      (sts)
  );

  axi_sts_register u_sts
  (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .sts_data      (sts),                           // Packed status, word 0 at the bottom
    .s_axi_araddr  (s_axi_sts_araddr),
    .s_axi_arvalid (s_axi_sts_arvalid),
    .s_axi_arready (s_axi_sts_arready),
    .s_axi_rdata   (s_axi_sts_rdata),
    .s_axi_rresp   (s_axi_sts_rresp),
    .s_axi_rvalid  (s_axi_sts_rvalid),
    .s_axi_rready  (s_axi_sts_rready)
  );

endmodule

// File: sim/axi_lite_bfm.svh
`ifndef AXI_LITE_BFM_SVH
`define AXI_LITE_BFM_SVH

// Full-word write on the config port, address and data offered together
task automatic axi_write(input logic [axi_addr_width-1:0] addr,
                         input logic [axi_data_width-1:0] data);
  int cycles;
  int stall;
  stall = int'($urandom % 3);                    // Cycles bready stays low after bvalid
  s_axi_cfg_awaddr  <= addr;
  s_axi_cfg_awvalid <= 1'b1;
  s_axi_cfg_wdata   <= data;
  s_axi_cfg_wvalid  <= 1'b1;
  cycles = 0;
  do
  begin
    @(posedge aclk);
    cycles++;
    if (cycles > wait_limit)
    begin
      $display("Timeout: awready and wready never rose on the config port");
      end_with_failure();
    end
  end
  while (!(s_axi_cfg_awready && s_axi_cfg_wready));
  s_axi_cfg_awvalid <= 1'b0;
  s_axi_cfg_wvalid  <= 1'b0;
  cycles = 0;
  while (!s_axi_cfg_bvalid)
  begin
    @(posedge aclk);
    cycles++;
    if (cycles > wait_limit)
    begin
      $display("Timeout: bvalid never rose on the config port");
      end_with_failure();
    end
  end
  repeat (stall)
  begin
    @(posedge aclk);
    check_value(s_axi_cfg_bvalid, 1'b1, "bvalid while bready is low");
  end
  s_axi_cfg_bready <= 1'b1;
  @(posedge aclk);                               // Response transfer edge
  check_value(s_axi_cfg_bresp, '0, "bresp");
  s_axi_cfg_bready <= 1'b0;
endtask

// Single read on either port, rready raised a few cycles after rvalid
task automatic axi_read(input  bit                        sts_port,
                        input  logic [axi_addr_width-1:0] addr,
                        output logic [axi_data_width-1:0] data);
  int cycles;
  int stall;
  stall = int'($urandom % 3);
  if (sts_port)
  begin
    s_axi_sts_araddr  <= addr;
    s_axi_sts_arvalid <= 1'b1;
  end
  else
  begin
    s_axi_cfg_araddr  <= addr;
    s_axi_cfg_arvalid <= 1'b1;
  end
  cycles = 0;
  do
  begin
    @(posedge aclk);
    cycles++;
    if (cycles > wait_limit)
    begin
      $display("Timeout: arready never rose on the %s port", sts_port ? "status" : "config");
      end_with_failure();
    end
  end
  while (!(sts_port ? s_axi_sts_arready : s_axi_cfg_arready));
  s_axi_sts_arvalid <= 1'b0;                     // Only one of the two was raised
  s_axi_cfg_arvalid <= 1'b0;
  cycles = 0;
  while (!(sts_port ? s_axi_sts_rvalid : s_axi_cfg_rvalid))
  begin
    @(posedge aclk);
    cycles++;
    if (cycles > wait_limit)
    begin
      $display("Timeout: rvalid never rose on the %s port", sts_port ? "status" : "config");
      end_with_failure();
    end
  end
  repeat (stall)
  begin
    @(posedge aclk);
    check_value(sts_port ? s_axi_sts_rvalid : s_axi_cfg_rvalid, 1'b1,
                "rvalid while rready is low");
  end
  if (sts_port)
  begin
    s_axi_sts_rready <= 1'b1;
  end
  else
  begin
    s_axi_cfg_rready <= 1'b1;
  end
  @(posedge aclk);                               // Data transfer edge
  data = sts_port ? s_axi_sts_rdata : s_axi_cfg_rdata;
  check_value(sts_port ? s_axi_sts_rresp : s_axi_cfg_rresp, '0, "rresp");
  s_axi_sts_rready <= 1'b0;
  s_axi_cfg_rready <= 1'b0;
endtask

`endif

// File: sim/evc_top_tb.sv
`timescale 1ns/1ps

module evc_top_tb;

  import evc_pkg::*;

  localparam int wait_limit = 64;                 // Cycles any handshake may take

  typedef enum logic [1:0]
  {
    op_cfg_write,
    op_cfg_read,
    op_sts_read,
    op_pulse
  } op_t;

  typedef struct packed
  {
    op_t                       op;
    logic [axi_addr_width-1:0] addr;
    logic [axi_data_width-1:0] data;              // Pulse rows hold four 8-bit counts
    logic [axi_data_width-1:0] expected;
  } row_t;

  logic                      aclk;
  logic                      aresetn;
  logic [num_channels-1:0]   event_in;
  logic [axi_addr_width-1:0] s_axi_cfg_awaddr, s_axi_cfg_araddr, s_axi_sts_araddr;
  logic [axi_data_width-1:0] s_axi_cfg_wdata, s_axi_cfg_rdata, s_axi_sts_rdata;
  logic [1:0]                s_axi_cfg_bresp, s_axi_cfg_rresp, s_axi_sts_rresp;
  logic                      s_axi_cfg_awvalid, s_axi_cfg_awready, s_axi_cfg_wvalid;
  logic                      s_axi_cfg_wready, s_axi_cfg_bvalid, s_axi_cfg_bready;
  logic                      s_axi_cfg_arvalid, s_axi_cfg_arready, s_axi_cfg_rvalid;
  logic                      s_axi_cfg_rready, s_axi_sts_arvalid, s_axi_sts_arready;
  logic                      s_axi_sts_rvalid, s_axi_sts_rready;

  row_t                      rows [$];

  evc_top uut
  (
    .*
  );

  initial
  begin
    aclk = 1'b0;
    forever
    begin
      #2 aclk = ~aclk;
    end
  end

  task automatic end_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input logic [axi_data_width-1:0] actual,
                             input logic [axi_data_width-1:0] expected,
                             input string                     what);
    if (actual !== expected)
    begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
      end_with_failure();
    end
  endtask

  `include "axi_lite_bfm.svh"

  // Channel i gets counts[8*i +: 8] pulses, each followed by one to three low cycles
  task automatic send_pulses(input logic [axi_data_width-1:0] counts);
    int                      left [num_channels];
    int                      gap [num_channels];
    int                      pending;
    logic [num_channels-1:0] level;
    level   = '0;
    pending = 0;
    for (int i = 0; i < num_channels; i++)
    begin
      left[i] = int'(counts[8*i +: 8]);
      gap[i]  = int'($urandom % 3);
      pending += left[i];
    end
    while (pending > 0)
    begin
      @(posedge aclk);
      for (int i = 0; i < num_channels; i++)
      begin
        if (level[i])
        begin
          level[i] = 1'b0;                        // Single-cycle pulse
        end
        else if (gap[i] > 0)
        begin
          gap[i]--;
        end
        else if (left[i] > 0)
        begin
          level[i] = 1'b1;
          left[i]--;
          pending--;
          gap[i] = int'($urandom % 3);
        end
      end
      event_in <= level;
    end
    @(posedge aclk);
    event_in <= '0;
  endtask

  function automatic void add_row(input op_t                       op,
                                  input logic [axi_addr_width-1:0] addr,
                                  input logic [axi_data_width-1:0] data,
                                  input logic [axi_data_width-1:0] expected);
    rows.push_back(row_t'{op, addr, data, expected});
  endfunction

  // Expected counts follow the pulse rows, limit is 5
  function automatic void build_table();
    add_row(op_sts_read,  'h00, 0, 0);             // Reset values
    add_row(op_sts_read,  'h10, 0, 0);
    add_row(op_cfg_read,  'h00, 0, 0);
    add_row(op_cfg_read,  'h04, 0, 0);
    add_row(op_cfg_write, 'h00, 'hdead_be00, 0);  // Read-back, nothing enabled
    add_row(op_cfg_read,  'h00, 0, 'hdead_be00);
    add_row(op_cfg_write, 'h04, 5, 0);
    add_row(op_cfg_read,  'h04, 0, 5);
    add_row(op_cfg_write, 'h00, 'h07, 0);         // Channel 3 disabled
    add_row(op_pulse,     0, 'h0407_0203, 0);
    add_row(op_sts_read,  'h00, 0, 3);
    add_row(op_sts_read,  'h04, 0, 2);
    add_row(op_sts_read,  'h08, 0, 7);
    add_row(op_sts_read,  'h0c, 0, 0);
    add_row(op_sts_read,  'h10, 0, 'h4);
    add_row(op_cfg_write, 'h00, 'h0f, 0);
    add_row(op_pulse,     0, 'h0601_0301, 0);
    add_row(op_sts_read,  'h00, 0, 4);
    add_row(op_sts_read,  'h04, 0, 5);
    add_row(op_sts_read,  'h08, 0, 8);
    add_row(op_sts_read,  'h0c, 0, 6);
    add_row(op_sts_read,  'h10, 0, 'he);
    add_row(op_cfg_write, 'h00, 'h4f, 0);         // Clear channel 2, then release
    add_row(op_cfg_write, 'h00, 'h0f, 0);
    add_row(op_sts_read,  'h08, 0, 0);
    add_row(op_sts_read,  'h10, 0, 'ha);
    add_row(op_sts_read,  'h00, 0, 4);
    add_row(op_pulse,     0, 'h0004_0001, 0);
    add_row(op_sts_read,  'h00, 0, 5);
    add_row(op_sts_read,  'h08, 0, 4);
    add_row(op_sts_read,  'h10, 0, 'hb);
    add_row(op_pulse,     0, 'h0001_0200, 0);     // Flag 1 stays set
    add_row(op_sts_read,  'h04, 0, 7);
    add_row(op_sts_read,  'h08, 0, 5);
    add_row(op_sts_read,  'h10, 0, 'hf);
    add_row(op_sts_read,  'h14, 0, 0);            // Out-of-range words
    add_row(op_sts_read,  'h18, 0, 0);
    add_row(op_sts_read,  'h1c, 0, 0);
    add_row(op_cfg_write, 'h08, 'hffff_ffff, 0);
    add_row(op_cfg_read,  'h00, 0, 'h0f);         // Words 0 and 1 untouched
    add_row(op_cfg_read,  'h04, 0, 5);
    for (int a = 'h08; a < 'h20; a += 4)
    begin
      add_row(op_cfg_read, a, 0, 0);
    end
  endfunction

  initial
  begin
    row_t                      row;
    logic [axi_data_width-1:0] rdata;
    void'($urandom(32'hb9b3_2f28));
    aresetn           = 1'b0;
    event_in          = '0;
    s_axi_cfg_awaddr  = '0;
    s_axi_cfg_awvalid = 1'b0;
    s_axi_cfg_wdata   = '0;
    s_axi_cfg_wvalid  = 1'b0;
    s_axi_cfg_bready  = 1'b0;
    s_axi_cfg_araddr  = '0;
    s_axi_cfg_arvalid = 1'b0;
    s_axi_cfg_rready  = 1'b0;
    s_axi_sts_araddr  = '0;
    s_axi_sts_arvalid = 1'b0;
    s_axi_sts_rready  = 1'b0;
    build_table();
    repeat (5) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);
    foreach (rows[i])
    begin
      row = rows[i];
      case (row.op)
        op_cfg_write: axi_write(row.addr, row.data);
        op_cfg_read:
        begin
          axi_read(1'b0, row.addr, rdata);
          check_value(rdata, row.expected, $sformatf("config word at %h", row.addr));
        end
        op_sts_read:
        begin
          axi_read(1'b1, row.addr, rdata);
          check_value(rdata, row.expected, $sformatf("status word at %h", row.addr));
        end
        default:
        begin
          send_pulses(row.data);
          repeat (4) @(posedge aclk);             // Counts and flags settle
        end
      endcase
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: evc_top.f
+incdir+sim
design/evc_pkg.sv
design/axi_cfg_register.sv
design/axi_sts_register.sv
design/event_counter_bank.sv
design/evc_top.sv
sim/evc_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the evc_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module evc_top_tb \
  -f evc_top.f -o evc_top_sim

# The simulator exits nonzero on failure, the log decides the result
./obj_dir/evc_top_sim 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log || ! grep -q "Simulation finished: PASS" sim.log
then
  echo "Testbench reported failure, see sim.log"
  exit 1
fi
echo "Testbench passed"
